// File: core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Hardware threads
`define CORE_THREADS        2
`define CORE_THREAD_W       1

// Word addresses, instruction memory is word indexed
`define CORE_PC_W           8

// Register file
`define CORE_DATA_W         16
`define CORE_REGS           8
`define CORE_REG_W          3

// Instruction word and its fields
`define CORE_INSTR_W        24
`define CORE_OP_W           4
`define CORE_IMM_W          8

// Thread t boots at boot_addr + t * stride
`define CORE_THREAD_STRIDE  64

// Multiplier pipeline depth, issue to result
`define CORE_MUL_STAGES     3

`endif

// File: core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    // Opcodes, top field of the instruction word
    typedef enum logic [`CORE_OP_W-1:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_mul  = 4'd7,
        op_beq  = 4'd8,
        op_jmp  = 4'd9
    } opcode_e;

    typedef logic [`CORE_THREAD_W-1:0]      thread_id_t;
    typedef logic [`CORE_PC_W-1:0]          pc_t;
    typedef logic [`CORE_DATA_W-1:0]        data_t;
    typedef logic [`CORE_REG_W-1:0]         reg_addr_t;
    typedef logic [`CORE_INSTR_W-1:0]       instr_t;

    // Signed, relative to the branch's own pc for beq and jmp
    typedef logic signed [`CORE_IMM_W-1:0]  imm_t;

    // Field view of an instruction word, most significant first
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [`CORE_INSTR_W-`CORE_OP_W-3*`CORE_REG_W-`CORE_IMM_W-1:0] spare;
        imm_t       imm;
    } instr_fields_t;

endpackage

// File: fetch_unit.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module fetch_unit
(
    input   logic                   clock,
    input   logic                   reset,

    // Thread 0 start address
    input   core_pkg::pc_t          boot_addr,

    // Whole front end halts
    input   logic                   stall_fetch,

    // Redirect from the ALU
    input   logic                   take_branch,
    input   core_pkg::thread_id_t   branch_thread_id,
    input   core_pkg::pc_t          branch_pc,

    // Instruction memory, answers in the same cycle
    output  core_pkg::pc_t          imem_addr,
    input   core_pkg::instr_t       imem_data,

    // Fetch register to decode
    output  logic                   fetch_valid,
    output  core_pkg::thread_id_t   fetch_thread_id,
    output  core_pkg::pc_t          fetch_pc,
    output  core_pkg::instr_t       fetch_instr
);

import core_pkg::*;

// One pc per thread
pc_t        pc_q [`CORE_THREADS];
// Thread fetched this cycle
thread_id_t cur_thread;
logic       kill_cur;
logic       kill_reg;

assign imem_addr = pc_q[cur_thread];

// Redirect drops the fetch in flight and the fetch register of that thread
assign kill_cur = take_branch && (branch_thread_id == cur_thread);
assign kill_reg = take_branch && (branch_thread_id == fetch_thread_id);

////////////////////
// Program counters
always_ff @(posedge clock)
begin
    if (reset)
    begin
        cur_thread <= '0;
        for (int t = 0; t < `CORE_THREADS; t++)
            pc_q[t] <= boot_addr + pc_t'(t * `CORE_THREAD_STRIDE);
    end
    else
    begin
        // Alternate threads every unstalled cycle
        if (!stall_fetch)
        begin
            pc_q[cur_thread] <= pc_q[cur_thread] + 1'b1;
            cur_thread       <= cur_thread + 1'b1;
        end
        // Redirect overrides the increment, even under stall
        if (take_branch)
            pc_q[branch_thread_id] <= branch_pc;
    end
end

////////////////////
// Fetch register
always_ff @(posedge clock)
begin
    if (reset)
        fetch_valid <= 1'b0;
    else if (!stall_fetch)
        fetch_valid <= !kill_cur;
    else if (kill_reg)
        fetch_valid <= 1'b0;
end

// Payload follows the valid bit
always_ff @(posedge clock)
begin
    if (!stall_fetch)
    begin
        fetch_thread_id <= cur_thread;
        fetch_pc        <= imem_addr;
        fetch_instr     <= imem_data;
    end
end

// ALU execute register is cleared by the first reset edge
assert property (@(posedge clock) reset && $past(reset) |-> !take_branch)
    else $error("take_branch high during reset");

endmodule

// File: decode_unit.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module decode_unit
(
    input   logic                   clock,
    input   logic                   reset,

    // From the fetch register
    input   logic                   fetch_valid,
    input   core_pkg::thread_id_t   fetch_thread_id,
    input   core_pkg::pc_t          fetch_pc,
    input   core_pkg::instr_t       fetch_instr,

    // Redirect and writeback back-pressure
    input   logic                   take_branch,
    input   core_pkg::thread_id_t   branch_thread_id,
    input   logic                   alu_hold,

    // Register write from writeback
    input   logic                   wb_valid,
    input   core_pkg::thread_id_t   wb_thread_id,
    input   core_pkg::reg_addr_t    wb_dest,
    input   core_pkg::data_t        wb_data,

    output  logic                   stall_fetch,

    // Issue to the ALU
    output  logic                   alu_valid,
    output  core_pkg::thread_id_t   alu_thread_id,
    output  core_pkg::opcode_e      alu_op,
    output  core_pkg::reg_addr_t    alu_dest,
    output  core_pkg::pc_t          alu_pc,
    output  core_pkg::data_t        alu_src1,
    output  core_pkg::data_t        alu_src2,
    output  core_pkg::imm_t         alu_imm,

    // Issue to the multiplier
    output  logic                   mul_valid,
    output  core_pkg::thread_id_t   mul_thread_id,
    output  core_pkg::reg_addr_t    mul_dest,
    output  core_pkg::data_t        mul_src1,
    output  core_pkg::data_t        mul_src2
);

import core_pkg::*;

instr_fields_t  fields;
data_t          regs [`CORE_THREADS][`CORE_REGS];

// Scoreboard, one busy bit per thread and register
logic [`CORE_THREADS-1:0][`CORE_REGS-1:0] busy;
logic [`CORE_THREADS-1:0][`CORE_REGS-1:0] busy_now;
logic [`CORE_THREADS-1:0][`CORE_REGS-1:0] busy_set;
logic [`CORE_THREADS-1:0][`CORE_REGS-1:0] wb_clear;

logic           is_mul;
logic           is_alu;
logic           writes_rd;
logic           uses_rs1;
logic           uses_rs2;
logic           hazard;
logic           kill_fetch;
logic           issue;
data_t          src1;
data_t          src2;

////////////////////
// Decode and hazards
always_comb
begin
    fields    = instr_fields_t'(fetch_instr);
    is_mul    = fields.opcode == op_mul;
    writes_rd = fields.opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_mul};
    // Unknown opcodes and nop are dropped here
    is_alu    = (writes_rd && !is_mul) || fields.opcode inside {op_beq, op_jmp};
    uses_rs1  = writes_rd || fields.opcode == op_beq;
    uses_rs2  = uses_rs1 && fields.opcode != op_addi;

    // Writeback this cycle already counts as retired
    wb_clear = '0;
    if (wb_valid)
        wb_clear[wb_thread_id][wb_dest] = 1'b1;
    busy_now = busy & ~wb_clear;

    hazard = (uses_rs1  && busy_now[fetch_thread_id][fields.rs1])
          || (uses_rs2  && busy_now[fetch_thread_id][fields.rs2])
          || (writes_rd && busy_now[fetch_thread_id][fields.rd]);

    // Register read with same-cycle writeback pass-through
    src1 = regs[fetch_thread_id][fields.rs1];
    if (wb_clear[fetch_thread_id][fields.rs1])
        src1 = wb_data;
    src2 = regs[fetch_thread_id][fields.rs2];
    if (wb_clear[fetch_thread_id][fields.rs2])
        src2 = wb_data;

    stall_fetch = alu_hold || (fetch_valid && hazard);

    // Younger instruction of a branching thread never issues
    kill_fetch = take_branch && (branch_thread_id == fetch_thread_id);
    issue      = fetch_valid && !stall_fetch && !kill_fetch;

    busy_set = '0;
    if (issue && writes_rd)
        busy_set[fetch_thread_id][fields.rd] = 1'b1;
end

////////////////////
// Register file and scoreboard
always_ff @(posedge clock)
begin
    if (reset)
    begin
        busy <= '0;
        for (int t = 0; t < `CORE_THREADS; t++)
            for (int r = 0; r < `CORE_REGS; r++)
                regs[t][r] <= '0;
    end
    else
    begin
        busy <= busy_now | busy_set;
        if (wb_valid)
            regs[wb_thread_id][wb_dest] <= wb_data;
    end
end

////////////////////
// Issue registers
always_ff @(posedge clock)
begin
    if (reset)
    begin
        alu_valid <= 1'b0;
        mul_valid <= 1'b0;
    end
    else
    begin
        // ALU slot waits while its result is blocked at writeback
        if (!alu_hold)
            alu_valid <= issue && is_alu;
        mul_valid <= issue && is_mul;
    end
end

always_ff @(posedge clock)
begin
    if (issue && is_alu)
    begin
        alu_thread_id <= fetch_thread_id;
        alu_op        <= fields.opcode;
        alu_dest      <= fields.rd;
        alu_pc        <= fetch_pc;
        alu_src1      <= src1;
        alu_src2      <= src2;
        alu_imm       <= fields.imm;
    end
    if (issue && is_mul)
    begin
        mul_thread_id <= fetch_thread_id;
        mul_dest      <= fields.rd;
        mul_src1      <= src1;
        mul_src2      <= src2;
    end
end

// Held ALU slot and a fresh multiply never overlap
assert property (@(posedge clock) disable iff (reset) !(alu_valid && mul_valid))
    else $error("alu_valid and mul_valid both high");

// Every retired write was scoreboarded at issue
assert property (@(posedge clock) disable iff (reset)
    wb_valid |-> busy[wb_thread_id][wb_dest])
    else $error("writeback to a register that is not busy");

endmodule

// File: alu_unit.sv
`timescale 1ns/10ps

module alu_unit
(
    input   logic                   clock,
    input   logic                   reset,

    // Issue from decode
    input   logic                   alu_valid,
    input   core_pkg::thread_id_t   alu_thread_id,
    input   core_pkg::opcode_e      alu_op,
    input   core_pkg::reg_addr_t    alu_dest,
    input   core_pkg::pc_t          alu_pc,
    input   core_pkg::data_t        alu_src1,
    input   core_pkg::data_t        alu_src2,
    input   core_pkg::imm_t         alu_imm,

    // Writeback lost arbitration
    input   logic                   alu_hold,

    // Redirect to fetch and decode
    output  logic                   take_branch,
    output  core_pkg::thread_id_t   branch_thread_id,
    output  core_pkg::pc_t          branch_pc,

    // Result to writeback
    output  logic                   alu_res_valid,
    output  core_pkg::thread_id_t   alu_res_thread_id,
    output  core_pkg::reg_addr_t    alu_res_dest,
    output  core_pkg::data_t        alu_res_data
);

import core_pkg::*;

// Execute register
logic       exec_valid;
thread_id_t exec_thread_id;
opcode_e    exec_op;
reg_addr_t  exec_dest;
pc_t        exec_pc;
data_t      exec_src1;
data_t      exec_src2;
imm_t       exec_imm;

data_t      imm_ext;
data_t      result;
logic       exec_writes;

////////////////////
// Execute register, holds with the result register
always_ff @(posedge clock)
begin
    if (reset)
        exec_valid <= 1'b0;
    else if (!alu_hold)
        exec_valid <= alu_valid;
end

always_ff @(posedge clock)
begin
    if (!alu_hold)
    begin
        exec_thread_id <= alu_thread_id;
        exec_op        <= alu_op;
        exec_dest      <= alu_dest;
        exec_pc        <= alu_pc;
        exec_src1      <= alu_src1;
        exec_src2      <= alu_src2;
        exec_imm       <= alu_imm;
    end
end

// Signed immediate, sign extended
assign imm_ext = exec_imm;

always_comb
begin
    case (exec_op)
        op_add:  result = exec_src1 + exec_src2;
        op_sub:  result = exec_src1 - exec_src2;
        op_and:  result = exec_src1 & exec_src2;
        op_or:   result = exec_src1 | exec_src2;
        op_xor:  result = exec_src1 ^ exec_src2;
        op_addi: result = exec_src1 + imm_ext;
        default: result = '0;
    endcase
end

// beq and jmp leave no result
assign exec_writes = exec_op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};

////////////////////
// Branch resolution, target relative to the branch pc
assign take_branch      = exec_valid
                       && (exec_op == op_jmp || (exec_op == op_beq && exec_src1 == exec_src2));
assign branch_thread_id = exec_thread_id;
assign branch_pc        = exec_pc + pc_t'(exec_imm);

////////////////////
// Result register
always_ff @(posedge clock)
begin
    if (reset)
        alu_res_valid <= 1'b0;
    else if (!alu_hold)
        alu_res_valid <= exec_valid && exec_writes;
end

always_ff @(posedge clock)
begin
    if (!alu_hold)
    begin
        alu_res_thread_id <= exec_thread_id;
        alu_res_dest      <= exec_dest;
        alu_res_data      <= result;
    end
end

endmodule

// File: mul_unit.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module mul_unit
(
    input   logic                   clock,
    input   logic                   reset,

    // Issue from decode
    input   logic                   mul_valid,
    input   core_pkg::thread_id_t   mul_thread_id,
    input   core_pkg::reg_addr_t    mul_dest,
    input   core_pkg::data_t        mul_src1,
    input   core_pkg::data_t        mul_src2,

    // Result to writeback, fixed latency
    output  logic                   mul_res_valid,
    output  core_pkg::thread_id_t   mul_res_thread_id,
    output  core_pkg::reg_addr_t    mul_res_dest,
    output  core_pkg::data_t        mul_res_data
);

import core_pkg::*;

// One entry per stage, never stalls
logic       st_valid  [`CORE_MUL_STAGES];
thread_id_t st_thread [`CORE_MUL_STAGES];
reg_addr_t  st_dest   [`CORE_MUL_STAGES];
data_t      st_data   [`CORE_MUL_STAGES];

always_ff @(posedge clock)
begin
    if (reset)
    begin
        for (int s = 0; s < `CORE_MUL_STAGES; s++)
            st_valid[s] <= 1'b0;
    end
    else
    begin
        st_valid[0] <= mul_valid;
        for (int s = 1; s < `CORE_MUL_STAGES; s++)
            st_valid[s] <= st_valid[s-1];
    end
end

always_ff @(posedge clock)
begin
    // Low half of the product only
    st_data[0]   <= mul_src1 * mul_src2;
    st_thread[0] <= mul_thread_id;
    st_dest[0]   <= mul_dest;
    for (int s = 1; s < `CORE_MUL_STAGES; s++)
    begin
        st_data[s]   <= st_data[s-1];
        st_thread[s] <= st_thread[s-1];
        st_dest[s]   <= st_dest[s-1];
    end
end

assign mul_res_valid     = st_valid[`CORE_MUL_STAGES-1];
assign mul_res_thread_id = st_thread[`CORE_MUL_STAGES-1];
assign mul_res_dest      = st_dest[`CORE_MUL_STAGES-1];
assign mul_res_data      = st_data[`CORE_MUL_STAGES-1];

endmodule

// File: writeback_unit.sv
`timescale 1ns/10ps

module writeback_unit
(
    input   logic                   clock,
    input   logic                   reset,

    // ALU result
    input   logic                   alu_res_valid,
    input   core_pkg::thread_id_t   alu_res_thread_id,
    input   core_pkg::reg_addr_t    alu_res_dest,
    input   core_pkg::data_t        alu_res_data,

    // Multiplier result, always wins
    input   logic                   mul_res_valid,
    input   core_pkg::thread_id_t   mul_res_thread_id,
    input   core_pkg::reg_addr_t    mul_res_dest,
    input   core_pkg::data_t        mul_res_data,

    output  logic                   alu_hold,

    // One register write per pulse
    output  logic                   wb_valid,
    output  core_pkg::thread_id_t   wb_thread_id,
    output  core_pkg::reg_addr_t    wb_dest,
    output  core_pkg::data_t        wb_data
);

// ALU loses on collision and retries next cycle
assign alu_hold = alu_res_valid && mul_res_valid;

always_ff @(posedge clock)
begin
    if (reset)
        wb_valid <= 1'b0;
    else
        wb_valid <= alu_res_valid || mul_res_valid;
end

always_ff @(posedge clock)
begin
    if (mul_res_valid)
    begin
        wb_thread_id <= mul_res_thread_id;
        wb_dest      <= mul_res_dest;
        wb_data      <= mul_res_data;
    end
    else if (alu_res_valid)
    begin
        wb_thread_id <= alu_res_thread_id;
        wb_dest      <= alu_res_dest;
        wb_data      <= alu_res_data;
    end
end

// Losing ALU result must still be there next cycle
assert property (@(posedge clock) disable iff (reset)
    alu_hold |=> alu_res_valid && $stable(alu_res_data)
              && $stable(alu_res_dest) && $stable(alu_res_thread_id))
    else $error("ALU result changed while held");

endmodule

// File: core_top.sv
`timescale 1ns/10ps

module core_top
(
    // System signals
    input   logic                   clock,
    input   logic                   reset,

    // Thread 0 start address
    input   core_pkg::pc_t          boot_addr,

    // Instruction memory, combinational read
    output  core_pkg::pc_t          imem_addr,
    input   core_pkg::instr_t       imem_data,

    // Register writes
    output  logic                   wb_valid,
    output  core_pkg::thread_id_t   wb_thread_id,
    output  core_pkg::reg_addr_t    wb_dest,
    output  core_pkg::data_t        wb_data
);

import core_pkg::*;

////////////////////
// Fetch to decode
logic       fetch_valid;
thread_id_t fetch_thread_id;
pc_t        fetch_pc;
instr_t     fetch_instr;
logic       stall_fetch;

////////////////////
// Decode to execution
logic       alu_valid;
thread_id_t alu_thread_id;
opcode_e    alu_op;
reg_addr_t  alu_dest;
pc_t        alu_pc;
data_t      alu_src1;
data_t      alu_src2;
imm_t       alu_imm;

logic       mul_valid;
thread_id_t mul_thread_id;
reg_addr_t  mul_dest;
data_t      mul_src1;
data_t      mul_src2;

// Redirect from the ALU
logic       take_branch;
thread_id_t branch_thread_id;
pc_t        branch_pc;

////////////////////
// Execution to writeback
logic       alu_res_valid;
thread_id_t alu_res_thread_id;
reg_addr_t  alu_res_dest;
data_t      alu_res_data;

logic       mul_res_valid;
thread_id_t mul_res_thread_id;
reg_addr_t  mul_res_dest;
data_t      mul_res_data;

logic       alu_hold;

// Wires share the port names, so every stage connects by name
fetch_unit
fetch_unit
(
    .*
);

decode_unit
decode_unit
(
    .*
);

alu_unit
alu_unit
(
    .*
);

mul_unit
mul_unit
(
    .*
);

writeback_unit
writeback_unit
(
    .*
);

endmodule

// File: core_tb.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_tb;

import core_pkg::*;

localparam int NUM_TESTS    = 4;
localparam int PROG_LEN     = 10;
localparam int DRAIN_CYCLES = 200;
localparam int NUM_QUEUES   = `CORE_THREADS * `CORE_REGS;
// Each test is reset, boot check and drain, plus slack
localparam int WATCHDOG_NS  = NUM_TESTS * (DRAIN_CYCLES + 8) * 10 + 1000;

logic       clock;
logic       reset;
pc_t        boot_addr;
pc_t        imem_addr;
instr_t     imem_data;
logic       wb_valid;
thread_id_t wb_thread_id;
reg_addr_t  wb_dest;
data_t      wb_data;

// Instruction memory, combinational read
instr_t     imem [1 << `CORE_PC_W];

// Test table
string      test_name [NUM_TESTS];
pc_t        test_boot [NUM_TESTS];
instr_t     prog      [NUM_TESTS][`CORE_THREADS][PROG_LEN];
int         prog_len  [NUM_TESTS][`CORE_THREADS];

// Expected writes, one queue per thread and register
data_t      exp_q [NUM_QUEUES][$];

int         test_errors;
int         writes_seen;
int         pass_count;
int         fail_count;

core_top uut
(
    .*
);

assign imem_data = imem[imem_addr];

////////////////////
// Clock
initial
begin
    clock = 1'b0;
    forever #5 clock = ~clock;
end

// Instruction word, fields from the top: opcode, rd, rs1, rs2, spare, imm
function automatic instr_t encode(opcode_e op, int rd, int rs1, int rs2, int imm);
    instr_t w;
    w        = '0;
    w[23:20] = op;
    w[19:17] = rd[2:0];
    w[16:14] = rs1[2:0];
    w[13:11] = rs2[2:0];
    w[7:0]   = imm[7:0];
    return w;
endfunction

task automatic add_instr(int k, int th, opcode_e op, int rd, int rs1, int rs2, int imm);
    prog[k][th][prog_len[k][th]] = encode(op, rd, rs1, rs2, imm);
    prog_len[k][th]++;
endtask

////////////////////
// Programs, thread 0 then thread 1
task automatic build_table();
    for (int k = 0; k < NUM_TESTS; k++)
        for (int th = 0; th < `CORE_THREADS; th++)
            prog_len[k][th] = 0;

    // ALU chains, same register numbers in both threads
    test_name[0] = "alu_chain";
    test_boot[0] = 8'h00;
    add_instr(0, 0, op_addi, 1, 0, 0, 5);
    add_instr(0, 0, op_addi, 2, 1, 0, 3);
    add_instr(0, 0, op_add,  3, 1, 2, 0);
    add_instr(0, 0, op_sub,  4, 3, 1, 0);
    add_instr(0, 0, op_xor,  5, 4, 2, 0);
    add_instr(0, 0, op_or,   6, 3, 4, 0);
    add_instr(0, 0, op_and,  7, 6, 2, 0);
    add_instr(0, 0, op_addi, 1, 1, 0, -2);
    add_instr(0, 1, op_addi, 1, 0, 0, 100);
    add_instr(0, 1, op_addi, 2, 0, 0, -7);
    add_instr(0, 1, op_add,  3, 1, 2, 0);
    add_instr(0, 1, op_sub,  1, 3, 2, 0);
    add_instr(0, 1, op_and,  4, 1, 2, 0);
    add_instr(0, 1, op_or,   5, 4, 3, 0);
    add_instr(0, 1, op_xor,  2, 5, 1, 0);

    // Products feeding ALU ops and further products
    test_name[1] = "mul_chain";
    test_boot[1] = 8'h10;
    add_instr(1, 0, op_addi, 1, 0, 0, 7);
    add_instr(1, 0, op_addi, 2, 0, 0, -3);
    add_instr(1, 0, op_mul,  3, 1, 2, 0);
    add_instr(1, 0, op_mul,  4, 3, 3, 0);
    add_instr(1, 0, op_add,  5, 4, 1, 0);
    add_instr(1, 0, op_mul,  1, 5, 2, 0);
    add_instr(1, 1, op_addi, 1, 0, 0, 100);
    add_instr(1, 1, op_mul,  2, 1, 1, 0);
    add_instr(1, 1, op_mul,  3, 2, 1, 0);
    add_instr(1, 1, op_addi, 2, 3, 0, 1);
    add_instr(1, 1, op_mul,  4, 2, 2, 0);

    // Taken and not-taken beq, forward jmp
    test_name[2] = "branches";
    test_boot[2] = 8'h20;
    add_instr(2, 0, op_addi, 1, 0, 0, 3);
    add_instr(2, 0, op_addi, 2, 0, 0, 3);
    add_instr(2, 0, op_beq,  0, 1, 2, 3);
    add_instr(2, 0, op_addi, 3, 0, 0, 7);
    add_instr(2, 0, op_addi, 4, 0, 0, 9);
    add_instr(2, 0, op_addi, 5, 0, 0, 1);
    add_instr(2, 0, op_beq,  0, 1, 5, 2);
    add_instr(2, 0, op_addi, 6, 0, 0, 2);
    add_instr(2, 1, op_jmp,  0, 0, 0, 3);
    add_instr(2, 1, op_addi, 1, 0, 0, 11);
    add_instr(2, 1, op_addi, 2, 0, 0, 12);
    add_instr(2, 1, op_addi, 1, 0, 0, 5);
    add_instr(2, 1, op_beq,  0, 0, 0, 2);
    add_instr(2, 1, op_addi, 7, 0, 0, 1);
    add_instr(2, 1, op_addi, 2, 1, 0, -1);

    // Products and independent ALU ops meeting at writeback
    test_name[3] = "wb_contention";
    test_boot[3] = 8'h05;
    add_instr(3, 0, op_addi, 1, 0, 0, 3);
    add_instr(3, 0, op_addi, 2, 0, 0, 4);
    add_instr(3, 0, op_mul,  3, 1, 2, 0);
    add_instr(3, 0, op_addi, 4, 0, 0, 1);
    add_instr(3, 0, op_addi, 5, 0, 0, 2);
    add_instr(3, 0, op_addi, 6, 0, 0, 3);
    add_instr(3, 0, op_addi, 7, 4, 0, 5);
    add_instr(3, 1, op_addi, 1, 0, 0, 9);
    add_instr(3, 1, op_mul,  2, 1, 1, 0);
    add_instr(3, 1, op_mul,  3, 1, 1, 0);
    add_instr(3, 1, op_addi, 4, 0, 0, 6);
    add_instr(3, 1, op_addi, 5, 4, 0, 1);
    add_instr(3, 1, op_mul,  6, 5, 1, 0);
    add_instr(3, 1, op_addi, 7, 0, 0, 8);
endtask

// Nop fill carries its own address, then each program closed by a jmp to itself
task automatic load_program(int k);
    pc_t base;
    for (int a = 0; a < (1 << `CORE_PC_W); a++)
        imem[a] = instr_t'({4'h0, 12'h000, a[7:0]});
    for (int th = 0; th < `CORE_THREADS; th++)
    begin
        base = test_boot[k] + pc_t'(th * `CORE_THREAD_STRIDE);
        for (int i = 0; i < prog_len[k][th]; i++)
            imem[base + pc_t'(i)] = prog[k][th][i];
        imem[base + pc_t'(prog_len[k][th])] = encode(op_jmp, 0, 0, 0, 0);
    end
endtask

////////////////////
// Reference model, one thread in program order
task automatic model_thread(int th, pc_t start);
    data_t      r [`CORE_REGS];
    pc_t        pc;
    instr_t     w;
    opcode_e    op;
    logic [7:0] imm;
    data_t      res;
    logic       writes;
    logic       done;
    for (int i = 0; i < `CORE_REGS; i++)
        r[i] = '0;
    pc   = start;
    done = 1'b0;
    for (int step = 0; step < 64 && !done; step++)
    begin
        w      = imem[pc];
        op     = opcode_e'(w[23:20]);
        imm    = w[7:0];
        writes = 1'b1;
        res    = '0;
        case (op)
            op_add:  res = r[w[16:14]] + r[w[13:11]];
            op_sub:  res = r[w[16:14]] - r[w[13:11]];
            op_and:  res = r[w[16:14]] & r[w[13:11]];
            op_or:   res = r[w[16:14]] | r[w[13:11]];
            op_xor:  res = r[w[16:14]] ^ r[w[13:11]];
            op_addi: res = r[w[16:14]] + {{8{imm[7]}}, imm};
            // Low half of the product
            op_mul:  res = r[w[16:14]] * r[w[13:11]];
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            r[w[19:17]] = res;
            exp_q[th * `CORE_REGS + int'(w[19:17])].push_back(res);
        end
        // Branch targets relative to the branch pc
        if (op == op_jmp && imm == 8'h00)
            done = 1'b1;
        else if (op == op_jmp || (op == op_beq && r[w[16:14]] == r[w[13:11]]))
            pc = pc + imm;
        else
            pc = pc + 1'b1;
    end
endtask

////////////////////
// Writeback checker
task automatic check_write();
    int    idx;
    data_t exp;
    idx = int'(wb_thread_id) * `CORE_REGS + int'(wb_dest);
    writes_seen++;
    assert (exp_q[idx].size() > 0)
    else
    begin
        $display("Thread %0d register %0d written with no write left to expect",
                 wb_thread_id, wb_dest);
        test_errors++;
    end
    if (exp_q[idx].size() > 0)
    begin
        exp = exp_q[idx].pop_front();
        assert (wb_data === exp)
        else
        begin
            $display("ERROR: wb_data thread %0d r%0d expected %h actual %h",
                     wb_thread_id, wb_dest, exp, wb_data);
            test_errors++;
        end
    end
endtask

// Outputs settle by the falling edge
always @(negedge clock)
begin
    if (reset)
    begin
        assert (wb_valid !== 1'b1)
        else
        begin
            $display("wb_valid went high while reset was asserted");
            test_errors++;
        end
    end
    else if (wb_valid === 1'b1)
        check_write();
end

task automatic run_test(int k);
    @(posedge clock);
    #1;
    reset     = 1'b1;
    boot_addr = test_boot[k];
    load_program(k);
    for (int q = 0; q < NUM_QUEUES; q++)
        exp_q[q].delete();
    for (int th = 0; th < `CORE_THREADS; th++)
        model_thread(th, test_boot[k] + pc_t'(th * `CORE_THREAD_STRIDE));
    test_errors = 0;
    writes_seen = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // Boot order, thread 0 then thread 1
    @(negedge clock);
    assert (imem_addr === test_boot[k])
    else
    begin
        $display("ERROR: imem_addr expected %h actual %h", test_boot[k], imem_addr);
        test_errors++;
    end
    @(negedge clock);
    assert (imem_addr === test_boot[k] + pc_t'(`CORE_THREAD_STRIDE))
    else
    begin
        $display("ERROR: imem_addr expected %h actual %h",
                 test_boot[k] + pc_t'(`CORE_THREAD_STRIDE), imem_addr);
        test_errors++;
    end

    repeat (DRAIN_CYCLES) @(posedge clock);
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
        assert (exp_q[q].size() == 0)
        else
        begin
            $display("Thread %0d register %0d is missing %0d expected writes",
                     q / `CORE_REGS, q % `CORE_REGS, exp_q[q].size());
            test_errors++;
        end
    end

    $display("%-14s %0d writes checked, %0d errors", test_name[k], writes_seen, test_errors);
    if (test_errors == 0)
        pass_count++;
    else
        fail_count++;
endtask

////////////////////
// Main sequence
initial
begin
    reset      = 1'b1;
    boot_addr  = '0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    load_program(0);
    for (int k = 0; k < NUM_TESTS; k++)
        run_test(k);
    $display("%0d tests clean, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0)
        $display("Test passed");
    else
        $display("Test failed");
    $finish;
end

// Watchdog
initial
begin
    #(WATCHDOG_NS);
    $display("Run exceeded its time limit of %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
end

endmodule

// File: project.f
+incdir+.
core_pkg.sv
fetch_unit.sv
decode_unit.sv
alu_unit.sv
mul_unit.sv
writeback_unit.sv
core_top.sv
core_tb.sv
